// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_riscboy_periph
FILELIST  ?= riscboy_periph.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The verdict comes from the simulation output only
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/apb_bridge.sv ====
`timescale 1ns/1ps

module apb_bridge import riscboy_periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   arst_n,

	input  logic   req_valid,
	output logic   req_ready,
	input  logic   req_write,
	input  paddr_t req_addr,
	input  word_t  req_wdata,

	output logic   resp_valid,
	input  logic   resp_ready,
	output word_t  resp_rdata,
	output logic   resp_err,

	output paddr_t paddr,
	output logic   psel,
	output logic   penable,
	output logic   pwrite,
	output word_t  pwdata,
	input  word_t  prdata,
	input  logic   pslverr
);

bridge_state_e state;

paddr_t addr_q;
word_t  wdata_q;
logic   write_q;

word_t  rdata_q;
logic   err_q;

// ====================
//  Control FSM
// ====================

always_ff @(posedge clk_sys or negedge arst_n) begin
	if (!arst_n) begin
		state <= BR_IDLE;
	end else begin
		case (state)
		BR_IDLE:   if (req_valid) state <= BR_SETUP;
		BR_SETUP:  state <= BR_ACCESS;
		BR_ACCESS: state <= BR_RESP;
		BR_RESP:   if (resp_ready) state <= BR_IDLE; // Host may stall us here
		default:   state <= BR_IDLE;
		endcase
	end
end

// Request is held for the whole transfer
always_ff @(posedge clk_sys or negedge arst_n) begin
	if (!arst_n) begin
		addr_q  <= '0;
		wdata_q <= '0;
		write_q <= 1'b0;
	end else if (req_valid && req_ready) begin
		addr_q  <= req_addr;
		wdata_q <= req_wdata;
		write_q <= req_write;
	end
end

// Result captured at the end of the access phase
always_ff @(posedge clk_sys or negedge arst_n) begin
	if (!arst_n) begin
		err_q   <= 1'b0;
		rdata_q <= '0;
	end else if (state == BR_ACCESS) begin
		err_q   <= pslverr;
		rdata_q <= (write_q || pslverr) ? '0 : prdata;
	end
end

assign req_ready  = state == BR_IDLE;
assign resp_valid = state == BR_RESP;
assign resp_rdata = rdata_q;
assign resp_err   = err_q;

assign psel    = (state == BR_SETUP) || (state == BR_ACCESS);
assign penable = state == BR_ACCESS;
assign paddr   = addr_q;
assign pwrite  = write_q;
assign pwdata  = wdata_q;

endmodule

// ==== hdl/apb_splitter.sv ====
`timescale 1ns/1ps

module apb_splitter import riscboy_periph_pkg::*; (
	input  paddr_t paddr,
	input  logic   psel,

	output logic   gpio_psel,
	output logic   pwm_psel,

	input  word_t  gpio_prdata,
	input  word_t  pwm_prdata,

	output word_t  prdata,
	output logic   pslverr
);

slot_e slot;

// Slot decode on the top address bits
always_comb begin
	case (paddr[SLOT_MSB:SLOT_LSB])
	GPIO_SLOT: slot = SLOT_GPIO;
	PWM_SLOT:  slot = SLOT_PWM;
	default:   slot = SLOT_NONE;
	endcase
end

assign gpio_psel = psel && (slot == SLOT_GPIO);
assign pwm_psel  = psel && (slot == SLOT_PWM);

// Read data back from whichever peripheral was hit
always_comb begin
	case (slot)
	SLOT_GPIO: begin
		prdata  = gpio_prdata;
		pslverr = 1'b0;
	end
	SLOT_PWM: begin
		prdata  = pwm_prdata;
		pslverr = 1'b0;
	end
	default: begin
		prdata  = '0;
		pslverr = 1'b1; // Nothing mapped here
	end
	endcase
end

endmodule

// ==== hdl/gpio.sv ====
`timescale 1ns/1ps

module gpio import riscboy_periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   arst_n,

	input  logic   psel,
	input  logic   penable,
	input  logic   pwrite,
	input  paddr_t paddr,
	input  word_t  pwdata,
	output word_t  prdata,

	input  pads_t  padin,
	input  logic   pwm_out,
	output pads_t  padout,
	output pads_t  padoe
);

pads_t out_q;
pads_t oe_q;
logic  fsel_q;   // Only bit 0 is implemented
pads_t in_meta;
pads_t in_sync;

logic  wen;
assign wen = psel && penable && pwrite;

always_ff @(posedge clk_sys or negedge arst_n) begin
	if (!arst_n) begin
		out_q  <= '0;
		oe_q   <= '0;
		fsel_q <= 1'b0;
	end else if (wen) begin
		case ({paddr[3:2], 2'b00})
		GPIO_OUT:  out_q  <= pwdata[N_PADS-1:0];
		GPIO_OE:   oe_q   <= pwdata[N_PADS-1:0];
		GPIO_FSEL: fsel_q <= pwdata[0];
		default:   ; // IN is read-only
		endcase
	end
end

// Two-flop synchronizer on the pad inputs
always_ff @(posedge clk_sys or negedge arst_n) begin
	if (!arst_n) begin
		in_meta <= '0;
		in_sync <= '0;
	end else begin
		in_meta <= padin;
		in_sync <= in_meta;
	end
end

always_comb begin
	case ({paddr[3:2], 2'b00})
	GPIO_OUT:  prdata = {{(W_DATA-N_PADS){1'b0}}, out_q};
	GPIO_OE:   prdata = {{(W_DATA-N_PADS){1'b0}}, oe_q};
	GPIO_IN:   prdata = {{(W_DATA-N_PADS){1'b0}}, in_sync};
	default:   prdata = {{(W_DATA-1){1'b0}}, fsel_q};
	endcase
end

// Pad 0 can be handed over to the backlight PWM
assign padout = {out_q[N_PADS-1:1], fsel_q ? pwm_out : out_q[0]};
assign padoe  = {oe_q[N_PADS-1:1], oe_q[0] | fsel_q};

endmodule

// ==== hdl/pwm_tiny.sv ====
`timescale 1ns/1ps

module pwm_tiny import riscboy_periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   arst_n,

	input  logic   psel,
	input  logic   penable,
	input  logic   pwrite,
	input  paddr_t paddr,
	input  word_t  pwdata,
	output word_t  prdata,

	output logic   pwm_out
);

logic en_q;
pwm_t top_q;
pwm_t cmp_q;
pwm_t ctr;

logic wen;
assign wen = psel && penable && pwrite;

always_ff @(posedge clk_sys or negedge arst_n) begin
	if (!arst_n) begin
		en_q  <= 1'b0;
		top_q <= '0;
		cmp_q <= '0;
	end else if (wen) begin
		case ({paddr[3:2], 2'b00})
		PWM_CTRL: en_q  <= pwdata[0];
		PWM_TOP:  top_q <= pwdata[W_PWM-1:0];
		PWM_CMP:  cmp_q <= pwdata[W_PWM-1:0];
		default:  ;
		endcase
	end
end

// Counts 0..top inclusive, parked at zero when off
always_ff @(posedge clk_sys or negedge arst_n) begin
	if (!arst_n)
		ctr <= '0;
	else if (!en_q || ctr == top_q)
		ctr <= '0;
	else
		ctr <= ctr + 1'b1;
end

always_comb begin
	case ({paddr[3:2], 2'b00})
	PWM_CTRL: prdata = {{(W_DATA-1){1'b0}}, en_q};
	PWM_TOP:  prdata = {{(W_DATA-W_PWM){1'b0}}, top_q};
	PWM_CMP:  prdata = {{(W_DATA-W_PWM){1'b0}}, cmp_q};
	default:  prdata = '0;
	endcase
end

assign pwm_out = en_q && (ctr < cmp_q);

endmodule

// ==== hdl/riscboy_periph.sv ====
`timescale 1ns/1ps

module riscboy_periph import riscboy_periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   arst_n,

	input  logic   req_valid,
	output logic   req_ready,
	input  logic   req_write,
	input  paddr_t req_addr,
	input  word_t  req_wdata,

	output logic   resp_valid,
	input  logic   resp_ready,
	output word_t  resp_rdata,
	output logic   resp_err,

	input  pads_t  padin,
	output pads_t  padout,
	output pads_t  padoe
);

// ====================
//  Interconnect
// ====================

paddr_t paddr;
logic   psel;
logic   penable;
logic   pwrite;
word_t  pwdata;
word_t  prdata;
logic   pslverr;

logic   gpio_psel;
logic   pwm_psel;
word_t  gpio_prdata;
word_t  pwm_prdata;

logic   pwm_out;    // Backlight, routed through GPIO pad 0

// ====================
//  Bus fabric
// ====================

apb_bridge u_apb_bridge (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.req_valid  (req_valid),
	.req_ready  (req_ready),
	.req_write  (req_write),
	.req_addr   (req_addr),
	.req_wdata  (req_wdata),
	.resp_valid (resp_valid),
	.resp_ready (resp_ready),
	.resp_rdata (resp_rdata),
	.resp_err   (resp_err),
	.paddr      (paddr),
	.psel       (psel),
	.penable    (penable),
	.pwrite     (pwrite),
	.pwdata     (pwdata),
	.prdata     (prdata),
	.pslverr    (pslverr)
);

apb_splitter u_apb_splitter (
	.paddr       (paddr),
	.psel        (psel),
	.gpio_psel   (gpio_psel),
	.pwm_psel    (pwm_psel),
	.gpio_prdata (gpio_prdata),
	.pwm_prdata  (pwm_prdata),
	.prdata      (prdata),
	.pslverr     (pslverr)
);

// ====================
//  Peripherals
// ====================

gpio u_gpio (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.psel    (gpio_psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (gpio_prdata),
	.padin   (padin),
	.pwm_out (pwm_out),
	.padout  (padout),
	.padoe   (padoe)
);

pwm_tiny u_pwm_tiny (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.psel    (pwm_psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (pwm_prdata),
	.pwm_out (pwm_out)
);

endmodule

// ==== hdl/riscboy_periph_pkg.sv ====
package riscboy_periph_pkg;

// ====================
//  Widths
// ====================

localparam W_PADDR = 16;
localparam W_DATA  = 32;
localparam N_PADS  = 8;
localparam W_PWM   = 8;

typedef logic [W_DATA-1:0]  word_t;
typedef logic [W_PADDR-1:0] paddr_t;
typedef logic [N_PADS-1:0]  pads_t;
typedef logic [W_PWM-1:0]   pwm_t;

// ====================
//  Address map
// ====================

// Top four address bits pick the peripheral
localparam SLOT_MSB = 15;
localparam SLOT_LSB = 12;

localparam logic [SLOT_MSB-SLOT_LSB:0] GPIO_SLOT = 4'h0;
localparam logic [SLOT_MSB-SLOT_LSB:0] PWM_SLOT  = 4'h2;

// Register offsets, decoded on bits 3:2
localparam logic [3:0] GPIO_OUT  = 4'h0;
localparam logic [3:0] GPIO_OE   = 4'h4;
localparam logic [3:0] GPIO_IN   = 4'h8; // Read-only
localparam logic [3:0] GPIO_FSEL = 4'hc; // Bit 0 puts PWM on pad 0

localparam logic [3:0] PWM_CTRL = 4'h0; // Bit 0 is enable
localparam logic [3:0] PWM_TOP  = 4'h4;
localparam logic [3:0] PWM_CMP  = 4'h8;

typedef enum logic [1:0] {
	BR_IDLE,
	BR_SETUP,
	BR_ACCESS,
	BR_RESP
} bridge_state_e;

typedef enum logic [1:0] {
	SLOT_GPIO,
	SLOT_PWM,
	SLOT_NONE
} slot_e;

endpackage

// ==== riscboy_periph.f ====
hdl/riscboy_periph_pkg.sv
hdl/apb_bridge.sv
hdl/apb_splitter.sv
hdl/gpio.sv
hdl/pwm_tiny.sv
hdl/riscboy_periph.sv
testbench/riscboy_periph_sva.sv
testbench/tb_riscboy_periph.sv

// ==== testbench/riscboy_periph_sva.sv ====
`timescale 1ns/1ps

module riscboy_periph_sva import riscboy_periph_pkg::*; (
	input logic  clk_sys,
	input logic  arst_n,
	input logic  req_ready,
	input logic  resp_valid,
	input logic  resp_ready,
	input word_t resp_rdata,
	input logic  psel,
	input logic  penable,
	input logic  gpio_psel,
	input logic  pwm_psel
);

// ====================
//  Handshakes
// ====================

resp_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
	resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
	else $error("response dropped or changed before resp_ready");

no_req_in_xfer: assert property (@(posedge clk_sys) disable iff (!arst_n)
	psel |-> !req_ready) // One transfer in flight
	else $error("req_ready high during a bus transfer");

// ====================
//  Bus phases
// ====================

access_after_setup: assert property (@(posedge clk_sys) disable iff (!arst_n)
	penable |-> $past(psel) && !$past(penable))
	else $error("penable without a preceding setup cycle");

one_sel: assert property (@(posedge clk_sys) disable iff (!arst_n)
	!(gpio_psel && pwm_psel))
	else $error("both peripheral selects high");

endmodule

bind riscboy_periph riscboy_periph_sva u_riscboy_periph_sva (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.req_ready  (req_ready),
	.resp_valid (resp_valid),
	.resp_ready (resp_ready),
	.resp_rdata (resp_rdata),
	.psel       (psel),
	.penable    (penable),
	.gpio_psel  (gpio_psel),
	.pwm_psel   (pwm_psel)
);

// ==== testbench/tb_riscboy_periph.sv ====
`timescale 1ns/1ps

module tb_riscboy_periph import riscboy_periph_pkg::*; ();

localparam int TIMEOUT_CYCLES = 40;
localparam int N_RANDOM       = 300;

logic   clk_sys = 1'b0;
logic   arst_n;
logic   req_valid;
logic   req_ready;
logic   req_write;
paddr_t req_addr;
word_t  req_wdata;
logic   resp_valid;
logic   resp_ready;
word_t  resp_rdata;
logic   resp_err;
pads_t  padin;
pads_t  padout;
pads_t  padoe;

integer seed;

// Shadow registers for the reference model
pads_t out_s;
pads_t oe_s;
logic  fsel_s;
logic  en_s;
pwm_t  top_s;
pwm_t  cmp_s;
pads_t padin_s;

word_t exp_data_q[$];
logic  exp_err_q[$];
word_t got_data_q[$];
logic  got_err_q[$];

riscboy_periph u_riscboy_periph (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.req_valid  (req_valid),
	.req_ready  (req_ready),
	.req_write  (req_write),
	.req_addr   (req_addr),
	.req_wdata  (req_wdata),
	.resp_valid (resp_valid),
	.resp_ready (resp_ready),
	.resp_rdata (resp_rdata),
	.resp_err   (resp_err),
	.padin      (padin),
	.padout     (padout),
	.padoe      (padoe)
);

always #10 clk_sys = ~clk_sys; // 20 ns period

// ====================
//  Checks
// ====================

task automatic stop_with_error(input string what);
	$display("%s", what);
	$display("SOME TESTS FAILED");
	$fatal(1, "simulation stopped at %0d ns", $time);
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
	if (act !== exp)
		stop_with_error($sformatf("mismatch at %0d ns: %s expected %h actual %h",
			$time, name, exp, act));
endtask

task automatic check_err(input string name, input logic exp, input logic act);
	if (act !== exp)
		stop_with_error($sformatf("mismatch at %0d ns: %s expected %b actual %b",
			$time, name, exp, act));
endtask

task automatic check_pads(input string name, input pads_t exp, input pads_t act);
	if (act !== exp)
		stop_with_error($sformatf("mismatch at %0d ns: %s expected %h actual %h",
			$time, name, exp, act));
endtask

// ====================
//  Reference model
// ====================

// Returns {err, rdata} for one access against the shadow registers
function automatic logic [W_DATA:0] ref_resp(input logic write, input paddr_t addr);
	logic [3:0] off;
	word_t      rdata;
	logic       err;
	off   = {addr[3:2], 2'b00};
	rdata = '0;
	err   = 1'b0;
	if (addr[SLOT_MSB:SLOT_LSB] == GPIO_SLOT) begin
		case (off)
		GPIO_OUT: rdata[N_PADS-1:0] = out_s;
		GPIO_OE:  rdata[N_PADS-1:0] = oe_s;
		GPIO_IN:  rdata[N_PADS-1:0] = padin_s;
		default:  rdata[0] = fsel_s;
		endcase
	end else if (addr[SLOT_MSB:SLOT_LSB] == PWM_SLOT) begin
		case (off)
		PWM_CTRL: rdata[0] = en_s;
		PWM_TOP:  rdata[W_PWM-1:0] = top_s;
		PWM_CMP:  rdata[W_PWM-1:0] = cmp_s;
		default:  ; // Hole in the PWM map reads zero
		endcase
	end else begin
		err = 1'b1;
	end
	if (write || err)
		rdata = '0;
	return {err, rdata};
endfunction

function automatic void shadow_write(input paddr_t addr, input word_t wdata);
	logic [3:0] off;
	off = {addr[3:2], 2'b00};
	if (addr[SLOT_MSB:SLOT_LSB] == GPIO_SLOT) begin
		case (off)
		GPIO_OUT:  out_s  = wdata[N_PADS-1:0];
		GPIO_OE:   oe_s   = wdata[N_PADS-1:0];
		GPIO_FSEL: fsel_s = wdata[0];
		default:   ; // IN ignores writes
		endcase
	end else if (addr[SLOT_MSB:SLOT_LSB] == PWM_SLOT) begin
		case (off)
		PWM_CTRL: en_s  = wdata[0];
		PWM_TOP:  top_s = wdata[W_PWM-1:0];
		PWM_CMP:  cmp_s = wdata[W_PWM-1:0];
		default:  ;
		endcase
	end
endfunction

function automatic word_t rand_word();
	word_t r;
	r = $random(seed);
	return r;
endfunction

// Pad 0 output belongs to the PWM while FSEL bit 0 is set
task automatic check_pad_state();
	pads_t mask;
	mask = {{(N_PADS-1){1'b1}}, ~fsel_s};
	check_pads("padout", out_s & mask, padout & mask);
	check_pads("padoe", {oe_s[N_PADS-1:1], oe_s[0] | fsel_s}, padoe);
endtask

// ====================
//  Host side
// ====================

task automatic bus_xfer(input logic write, input paddr_t addr, input word_t wdata,
		input logic [2:0] stall);
	logic [W_DATA:0] exp;
	int              n;
	exp = ref_resp(write, addr);
	exp_data_q.push_back(exp[W_DATA-1:0]);
	exp_err_q.push_back(exp[W_DATA]);
	if (write)
		shadow_write(addr, wdata);
	req_valid = 1'b1;
	req_write = write;
	req_addr  = addr;
	req_wdata = wdata;
	n = 0;
	while (!req_ready) begin
		@(posedge clk_sys);
		#1;
		n++;
		if (n > TIMEOUT_CYCLES)
			stop_with_error("timeout waiting for the bridge to accept a request");
	end
	@(posedge clk_sys); // Acceptance edge
	#1;
	req_valid = 1'b0;
	n = 0;
	while (!resp_valid) begin
		@(posedge clk_sys);
		#1;
		n++;
		if (n > TIMEOUT_CYCLES)
			stop_with_error("timeout waiting for resp_valid after an accepted request");
	end
	if (n != 2)
		stop_with_error($sformatf(
			"mismatch at %0d ns: resp_valid latency expected 2 actual %0d", $time, n));
	repeat (stall) begin
		@(posedge clk_sys);
		#1;
		if (!resp_valid || req_ready)
			stop_with_error("bridge left the response state while resp_ready was low");
	end
	got_data_q.push_back(resp_rdata);
	got_err_q.push_back(resp_err);
	resp_ready = 1'b1;
	@(posedge clk_sys);
	#1;
	resp_ready = 1'b0;
	check_pad_state();
endtask

task automatic read_all_regs();
	for (int i = 0; i < 4; i++)
		bus_xfer(1'b0, {GPIO_SLOT, 8'h00, i[1:0], 2'b00}, '0, 3'd0);
	for (int i = 0; i < 4; i++)
		bus_xfer(1'b0, {PWM_SLOT, 8'h00, i[1:0], 2'b00}, '0, 3'd1);
endtask

// Counts high cycles of pad 0 over one full PWM period
task automatic check_pwm_duty(input pwm_t top, input pwm_t cmp);
	int high;
	int exp;
	high = 0;
	repeat (int'(top) + 1) begin
		@(posedge clk_sys);
		#1;
		if (padout[0])
			high++;
	end
	exp = (int'(cmp) < int'(top) + 1) ? int'(cmp) : int'(top) + 1;
	if (high != exp)
		stop_with_error($sformatf(
			"mismatch at %0d ns: pwm high cycles expected %0d actual %0d",
			$time, exp, high));
endtask

// Compares one response per handshake edge
always @(posedge clk_sys) begin
	if (got_data_q.size() != 0) begin
		if (exp_data_q.size() == 0)
			stop_with_error("a response arrived with no expected value queued");
		check_word("resp_rdata", exp_data_q.pop_front(), got_data_q.pop_front());
		check_err("resp_err", exp_err_q.pop_front(), got_err_q.pop_front());
	end
end

// ====================
//  Stimulus
// ====================

initial begin
	word_t      r;
	logic [3:0] slot;
	seed       = 32'ha92c_7b1f;
	arst_n     = 1'b0;
	req_valid  = 1'b0;
	req_write  = 1'b0;
	req_addr   = '0;
	req_wdata  = '0;
	resp_ready = 1'b0;
	padin      = '0;
	out_s      = '0;
	oe_s       = '0;
	fsel_s     = 1'b0;
	en_s       = 1'b0;
	top_s      = '0;
	cmp_s      = '0;
	padin_s    = '0;
	repeat (10) @(posedge clk_sys);
	#1;
	arst_n = 1'b1;

	// Reset values
	check_err("resp_valid", 1'b0, resp_valid);
	check_pad_state();
	read_all_regs();

	// GPIO out and output enable
	bus_xfer(1'b1, {GPIO_SLOT, 8'h00, GPIO_OUT}, rand_word(), 3'd0);
	bus_xfer(1'b1, {GPIO_SLOT, 8'h00, GPIO_OE}, rand_word(), 3'd2);
	bus_xfer(1'b0, {GPIO_SLOT, 8'h00, GPIO_OUT}, '0, 3'd0);
	bus_xfer(1'b0, {GPIO_SLOT, 8'h00, GPIO_OE}, '0, 3'd1);

	// Pad inputs through the synchronizer
	repeat (4) begin
		r       = rand_word();
		padin   = r[N_PADS-1:0];
		padin_s = r[N_PADS-1:0];
		bus_xfer(1'b0, {GPIO_SLOT, 8'h00, GPIO_IN}, '0, 3'd0);
	end

	// Unmapped slots must leave every register alone
	for (int i = 0; i < 8; i++) begin
		r    = rand_word();
		slot = (r[15:12] == GPIO_SLOT || r[15:12] == PWM_SLOT) ? 4'hf : r[15:12];
		bus_xfer(r[16], {slot, r[11:0]}, rand_word(), r[19:17]);
	end
	read_all_regs();

	// Backlight on pad 0
	bus_xfer(1'b1, {PWM_SLOT, 8'h00, PWM_TOP}, 32'd9, 3'd0);
	bus_xfer(1'b1, {PWM_SLOT, 8'h00, PWM_CMP}, 32'd4, 3'd0);
	bus_xfer(1'b1, {GPIO_SLOT, 8'h00, GPIO_FSEL}, 32'd1, 3'd0);
	bus_xfer(1'b1, {PWM_SLOT, 8'h00, PWM_CTRL}, 32'd1, 3'd0);
	check_pads("padoe[0]", 8'h01, padoe & 8'h01);
	check_pwm_duty(top_s, cmp_s);
	bus_xfer(1'b1, {PWM_SLOT, 8'h00, PWM_CMP}, 32'd14, 3'd3); // Above top so always on
	check_pwm_duty(top_s, cmp_s);
	bus_xfer(1'b1, {PWM_SLOT, 8'h00, PWM_CMP}, 32'd0, 3'd1);
	check_pwm_duty(top_s, cmp_s);

	// Random mix with back-pressure
	r       = rand_word();
	padin   = r[N_PADS-1:0];
	padin_s = r[N_PADS-1:0];
	for (int i = 0; i < N_RANDOM; i++) begin
		r = rand_word();
		case (r[17:16])
		2'd0:    slot = GPIO_SLOT;
		2'd1:    slot = PWM_SLOT;
		default: slot = r[15:12];
		endcase
		bus_xfer(r[18], {slot, r[11:4], r[3:2], 2'b00}, rand_word(), r[21:19]);
	end

	@(posedge clk_sys);
	#1;
	if (exp_data_q.size() == 0 && got_data_q.size() == 0) begin
		$display("ALL TESTS PASSED");
		$finish;
	end else begin
		stop_with_error("responses were left uncompared at the end of the run");
	end
end

endmodule
